/* hdl/rayGenPkg.sv */
package rayGenPkg;

    //////////////////////////////////////////////////////////////////////
    // Fixed point format
    //////////////////////////////////////////////////////////////////////

    // Fraction bits of the Q16.16 format
    localparam int fracBits = 16;

    // Signed Q16.16 scalar
    typedef logic signed [31:0] fixedT;

    // Three component vector
    typedef struct packed {
        fixedT x;
        fixedT y;
        fixedT z;
    } vec3T;

    //////////////////////////////////////////////////////////////////////
    // Framebuffer and ray cores
    //////////////////////////////////////////////////////////////////////

    // Framebuffer size in pixels
    localparam int fbWidth  = 8;
    localparam int fbHeight = 4;

    // Pixel coordinate width
    localparam int coordW = 10;
    typedef logic [coordW-1:0] screenCoordT;

    // Ray cores fed in round-robin order
    localparam int numCores = 2;

    // One bit is enough for two cores
    typedef logic [$clog2(numCores > 1 ? numCores : 2)-1:0] coreIdxT;

    //////////////////////////////////////////////////////////////////////
    // Camera and controller
    //////////////////////////////////////////////////////////////////////

    // Camera basis, 448 bits
    typedef struct packed {
        // Eye position
        vec3T  pos;
        // Bottom left corner of the view plane
        vec3T  blc;
        // Horizontal and vertical plane axes
        vec3T  rh;
        vec3T  rv;
        // Per pixel steps along the axes
        fixedT cub;
        fixedT cvb;
    } cameraT;

    // Generator states
    typedef enum logic [1:0] {
        stIdle,
        stArmed,
        stGenerate,
        stAdvance
    } genStateT;

endpackage

/* hdl/scanIf.sv */
interface scanIf;
    import rayGenPkg::*;

    // Current scan position
    screenCoordT x;
    screenCoordT y;
    // Core that receives the current pixel
    coreIdxT     coreIdx;
    // Step to the next pixel on this edge
    logic        advance;
    // Position is the final pixel of the frame
    logic        lastPixel;

    // Pixel and core counters
    modport counter (output x, y, coreIdx, lastPixel, input advance);

    // Generator FSM
    modport control (output advance, input coreIdx, lastPixel);

    // Output register stage
    modport sink (input x, y, coreIdx);

endinterface

/* hdl/pixelScanner.sv */
module pixelScanner (
    input  logic   clk,
    input  logic   resetn,
    scanIf.counter scan,
    input  logic   clear
);
    import rayGenPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Counter limits
    //////////////////////////////////////////////////////////////////////

    localparam screenCoordT xLast    = screenCoordT'(fbWidth - 1);
    localparam screenCoordT yLast    = screenCoordT'(fbHeight - 1);
    localparam coreIdxT     coreLast = coreIdxT'(numCores - 1);

    // Position and core registers
    screenCoordT xPos;
    screenCoordT yPos;
    coreIdxT     corePos;

    // Row end decode
    logic        rowEnd;

    assign rowEnd = (xPos == xLast);

    //////////////////////////////////////////////////////////////////////
    // Raster walk and round-robin core
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            xPos    <= '0;
            yPos    <= '0;
            corePos <= '0;
        end else if (clear) begin
            // Back to pixel (0,0) on core 0
            xPos    <= '0;
            yPos    <= '0;
            corePos <= '0;
        end else if (scan.advance) begin
            if (rowEnd) begin
                xPos <= '0;
                // Frame wraps to the top row
                if (yPos == yLast) begin
                    yPos <= '0;
                end else begin
                    yPos <= yPos + 1'b1;
                end
            end else begin
                xPos <= xPos + 1'b1;
            end
            // Next core in turn
            if (corePos == coreLast) begin
                corePos <= '0;
            end else begin
                corePos <= corePos + 1'b1;
            end
        end
    end

    // Drive the scan bus
    assign scan.x         = xPos;
    assign scan.y         = yPos;
    assign scan.coreIdx   = corePos;
    // Bottom right pixel
    assign scan.lastPixel = rowEnd && (yPos == yLast);

endmodule

/* hdl/threadGenFsm.sv */
module threadGenFsm (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           arm,
    input  logic                           start,
    input  logic [rayGenPkg::numCores-1:0] outFull,
    scanIf.control                         scan,
    output logic                           clear,
    output logic                           issue,
    output logic                           frameDone
);
    import rayGenPkg::*;

    genStateT state;
    genStateT stateNext;

    // Almost-full flag of the core in turn
    logic     coreFull;
    // Last pixel is being stepped past
    logic     frameEnd;

    assign coreFull = outFull[scan.coreIdx];
    assign frameEnd = (state == stAdvance) && scan.lastPixel;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (arm) begin
                    stateNext = stArmed;
                end
            end
            stArmed: begin
                if (start) begin
                    stateNext = stGenerate;
                end
            end
            stGenerate: begin
                // Stall here until the core in turn has room
                if (!coreFull) begin
                    stateNext = stAdvance;
                end
            end
            stAdvance: begin
                if (scan.lastPixel) begin
                    stateNext = stIdle;
                end else begin
                    stateNext = stGenerate;
                end
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State and frame end registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= stIdle;
            frameDone <= 1'b0;
        end else begin
            state     <= stateNext;
            // One cycle pulse after the final thread
            frameDone <= frameEnd;
        end
    end

    // Restart the counters when armed
    assign clear        = (state == stIdle) && arm;
    // Hand one pixel to the output stage
    assign issue        = (state == stGenerate) && !coreFull;
    // Step pixel and core
    assign scan.advance = (state == stAdvance);

endmodule

/* hdl/rayDirUnit.sv */
module rayDirUnit (
    input  rayGenPkg::screenCoordT x,
    input  rayGenPkg::screenCoordT y,
    input  rayGenPkg::cameraT      cam,
    output rayGenPkg::vec3T        dir
);
    import rayGenPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Fixed point helpers
    //////////////////////////////////////////////////////////////////////

    // Full product, arithmetic shift, keep low word
    function automatic fixedT fixedMul(input fixedT a, input fixedT b);
        logic signed [63:0] prod;
        prod = a * b;
        prod = prod >>> fracBits;
        return prod[31:0];
    endfunction

    // Scalar times vector
    function automatic vec3T vecScale(input fixedT s, input vec3T v);
        vec3T r;
        r.x = fixedMul(s, v.x);
        r.y = fixedMul(s, v.y);
        r.z = fixedMul(s, v.z);
        return r;
    endfunction

    // Component sum, wraps at 32 bits
    function automatic vec3T vecAdd(input vec3T a, input vec3T b);
        vec3T r;
        r.x = a.x + b.x;
        r.y = a.y + b.y;
        r.z = a.z + b.z;
        return r;
    endfunction

    // Component difference, wraps at 32 bits
    function automatic vec3T vecSub(input vec3T a, input vec3T b);
        vec3T r;
        r.x = a.x - b.x;
        r.y = a.y - b.y;
        r.z = a.z - b.z;
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    // Row counted up from the bottom of the view plane
    screenCoordT yFlip;
    // Coordinates in Q16.16
    fixedT       xFix;
    fixedT       yFix;
    // Plane offsets
    fixedT       u;
    fixedT       v;
    // Scaled axes
    vec3T        hVec;
    vec3T        vVec;
    // Partial sums
    vec3T        planeOff;
    vec3T        planePt;

    assign yFlip = screenCoordT'(fbHeight - 1) - y;

    // Integer to fixed point
    assign xFix = fixedT'(x) << fracBits;
    assign yFix = fixedT'(yFlip) << fracBits;

    // Two scalar multiplies
    assign u = fixedMul(xFix, cam.cub);
    assign v = fixedMul(yFix, cam.cvb);

    // Two vector scales
    assign hVec = vecScale(u, cam.rh);
    assign vVec = vecScale(v, cam.rv);

    // Point on the view plane
    assign planeOff = vecAdd(hVec, vVec);
    assign planePt  = vecAdd(planeOff, cam.blc);

    // Direction from the eye, not normalized
    assign dir = vecSub(planePt, cam.pos);

endmodule

/* hdl/threadDispatch.sv */
module threadDispatch (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           issue,
    scanIf.sink                            scan,
    input  rayGenPkg::vec3T                dir,
    output logic [rayGenPkg::numCores-1:0] threadValid,
    output rayGenPkg::screenCoordT         threadX,
    output rayGenPkg::screenCoordT         threadY,
    output rayGenPkg::vec3T                threadDir
);
    import rayGenPkg::*;

    // One-hot select of the core in turn
    logic [numCores-1:0] coreSel;

    always_comb begin
        for (int i = 0; i < numCores; i++) begin
            coreSel[i] = (scan.coreIdx == coreIdxT'(i));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Valid lines
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            threadValid <= '0;
        end else if (issue) begin
            // Single cycle strobe to one core
            threadValid <= coreSel;
        end else begin
            threadValid <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Thread word
    //////////////////////////////////////////////////////////////////////

    // Shared data lines, held until the next issue
    always_ff @(posedge clk) begin
        if (issue) begin
            threadX   <= scan.x;
            threadY   <= scan.y;
            threadDir <= dir;
        end
    end

endmodule

/* hdl/rayGenTop.sv */
module rayGenTop (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           arm,
    input  logic                           start,
    input  logic [rayGenPkg::numCores-1:0] outFull,
    input  rayGenPkg::vec3T                camPos,
    input  rayGenPkg::vec3T                camBlc,
    input  rayGenPkg::vec3T                camRh,
    input  rayGenPkg::vec3T                camRv,
    input  rayGenPkg::fixedT               camCub,
    input  rayGenPkg::fixedT               camCvb,
    output logic [rayGenPkg::numCores-1:0] threadValid,
    output rayGenPkg::screenCoordT         threadX,
    output rayGenPkg::screenCoordT         threadY,
    output rayGenPkg::vec3T                threadDir,
    output logic                           frameDone
);
    import rayGenPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Internal wiring
    //////////////////////////////////////////////////////////////////////

    // Camera bundle for the datapath
    cameraT cam;
    // Counter restart on arm
    logic   clear;
    // Pixel taken by the output stage
    logic   issue;
    // Direction of the current pixel
    vec3T   dir;

    assign cam.pos = camPos;
    assign cam.blc = camBlc;
    assign cam.rh  = camRh;
    assign cam.rv  = camRv;
    assign cam.cub = camCub;
    assign cam.cvb = camCvb;

    // Scan position shared by counter, FSM and output stage
    scanIf scanBus ();

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////

    pixelScanner scanner (
        .clk    (clk),
        .resetn (resetn),
        .scan   (scanBus.counter),
        .clear  (clear)
    );

    threadGenFsm fsm (
        .clk       (clk),
        .resetn    (resetn),
        .arm       (arm),
        .start     (start),
        .outFull   (outFull),
        .scan      (scanBus.control),
        .clear     (clear),
        .issue     (issue),
        .frameDone (frameDone)
    );

    // Combinational direction of the pixel under the counter
    rayDirUnit dirUnit (
        .x   (scanBus.x),
        .y   (scanBus.y),
        .cam (cam),
        .dir (dir)
    );

    threadDispatch dispatch (
        .clk         (clk),
        .resetn      (resetn),
        .issue       (issue),
        .scan        (scanBus.sink),
        .dir         (dir),
        .threadValid (threadValid),
        .threadX     (threadX),
        .threadY     (threadY),
        .threadDir   (threadDir)
    );

endmodule

/* verif/rayGenTb.sv */
module rayGenTb;
    timeunit 1ns;
    timeprecision 1ps;
    import rayGenPkg::*;

    localparam int    numPixels = fbWidth * fbHeight;
    // Idle cycles allowed while waiting for a thread
    localparam int    waitLimit = 200;
    localparam string casePath  = "verif/rayGenCases.txt";

    //////////////////////////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////////////////////////

    logic                clk;
    logic                resetn;
    logic                arm;
    logic                start;
    logic [numCores-1:0] outFull = '0;
    vec3T                camPos;
    vec3T                camBlc;
    vec3T                camRh;
    vec3T                camRv;
    fixedT               camCub;
    fixedT               camCvb;
    logic [numCores-1:0] threadValid;
    screenCoordT         threadX;
    screenCoordT         threadY;
    vec3T                threadDir;
    logic                frameDone;

    // Back-pressure mode, cycle count and last full flags
    int                  bpMode = 0;
    int                  bpCycle = 0;
    logic [numCores-1:0] fullPrev = '0;

    // Scoreboard
    int                  errCount = 0;
    int                  testCount = 0;
    int                  testFails = 0;
    logic                aborted = 1'b0;

    rayGenTop i_dut (
        .clk         (clk),
        .resetn      (resetn),
        .arm         (arm),
        .start       (start),
        .outFull     (outFull),
        .camPos      (camPos),
        .camBlc      (camBlc),
        .camRh       (camRh),
        .camRv       (camRv),
        .camCub      (camCub),
        .camCvb      (camCvb),
        .threadValid (threadValid),
        .threadX     (threadX),
        .threadY     (threadY),
        .threadDir   (threadDir),
        .frameDone   (frameDone)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Back-pressure driver and monitor
    //////////////////////////////////////////////////////////////////////

    initial begin
        int unsigned rnd;
        // Fixed seed for the random full patterns
        rnd = $urandom(32'hff8f_9abe);
        forever begin
            @(posedge clk);
            bpCycle <= bpCycle + 1;
            outFull <= '0;
            if (bpMode == 1) begin
                // Core 0 full three cycles out of seven
                outFull[0] <= (bpCycle % 7) < 3;
            end else if (bpMode == 2) begin
                outFull <= numCores'(rnd);
                rnd = $urandom;
            end
        end
    end

    // A core full for two cycles must not see a valid
    always @(negedge clk) begin
        if (resetn) begin
            for (int c = 0; c < numCores; c++) begin
                if (threadValid[c] && outFull[c] && fullPrev[c]) begin
                    $display("Error at %0t ns: core %0d got a thread while full", $time, c);
                    errCount++;
                end
            end
        end
        fullPrev = outFull;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Q16.16 product as the low word of the shifted 64 bit result
    function automatic fixedT qMul(fixedT a, fixedT b);
        longint p;
        p = longint'(a) * longint'(b);
        return fixedT'(p >>> fracBits);
    endfunction

    function automatic vec3T expectDir(int px, int py);
        fixedT u;
        fixedT v;
        vec3T  d;
        u = qMul(fixedT'(px) <<< fracBits, camCub);
        // Rows counted from the bottom
        v = qMul(fixedT'(fbHeight - 1 - py) <<< fracBits, camCvb);
        d.x = qMul(u, camRh.x) + qMul(v, camRv.x) + camBlc.x - camPos.x;
        d.y = qMul(u, camRh.y) + qMul(v, camRv.y) + camBlc.y - camPos.y;
        d.z = qMul(u, camRh.z) + qMul(v, camRv.z) + camBlc.z - camPos.z;
        return d;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkCoord(string name, screenCoordT got, screenCoordT exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
            errCount++;
        end
    endtask

    task automatic checkDir(string name, vec3T got, vec3T exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s expected %h_%h_%h got %h_%h_%h", $time, name,
                     exp.x, exp.y, exp.z, got.x, got.y, got.z);
            errCount++;
        end
    endtask

    task automatic checkCore(string name, coreIdxT got, coreIdxT exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
            errCount++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequences
    //////////////////////////////////////////////////////////////////////

    // Start without arm must stay silent
    task automatic idleTest();
        int errStart;
        int cyc;
        errStart = errCount;
        cyc = 0;
        while (cyc < waitLimit / 2) begin
            @(negedge clk);
            cyc++;
            if (cyc == 20) begin
                @(posedge clk);
                start <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
            end
            if (|threadValid || frameDone) begin
                $display("Error at %0t ns: thread or frameDone seen without arm", $time);
                errCount++;
                break;
            end
        end
        testCount++;
        if (errCount != errStart) begin
            testFails++;
        end
        $display("Test idle: %0d errors", errCount - errStart);
    endtask

    // One frame with every thread checked against the model
    task automatic runFrame(string caseName, vec3T dir0, vec3T dirLast);
        int      errStart;
        int      n;
        int      idle;
        logic    done;
        coreIdxT gotCore;
        errStart = errCount;
        n = 0;
        idle = 0;
        done = 1'b0;
        @(posedge clk);
        arm <= 1'b1;
        @(posedge clk);
        arm   <= 1'b0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!done && !aborted) begin
            @(negedge clk);
            idle++;
            if (|threadValid) begin
                idle = 0;
                gotCore = '0;
                if ($countones(threadValid) != 1) begin
                    $display("Error at %0t ns: more than one core valid", $time);
                    errCount++;
                end
                for (int c = 0; c < numCores; c++) begin
                    if (threadValid[c]) begin
                        gotCore = coreIdxT'(c);
                    end
                end
                if (n >= numPixels) begin
                    $display("Error at %0t ns: thread past the end of the frame", $time);
                    errCount++;
                end else begin
                    checkCore("threadValid core", gotCore, coreIdxT'(n % numCores));
                    checkCoord("threadX", threadX, screenCoordT'(n % fbWidth));
                    checkCoord("threadY", threadY, screenCoordT'(n / fbWidth));
                    checkDir("threadDir", threadDir, expectDir(n % fbWidth, n / fbWidth));
                    // Precomputed corners from the case file
                    if (n == 0) begin
                        checkDir("threadDir first", threadDir, dir0);
                    end
                    if (n == numPixels - 1) begin
                        checkDir("threadDir last", threadDir, dirLast);
                    end
                end
                n++;
            end
            if (frameDone) begin
                done = 1'b1;
                if (n != numPixels) begin
                    $display("Error at %0t ns: frameDone after %0d threads, not %0d",
                             $time, n, numPixels);
                    errCount++;
                end
            end else if (idle > waitLimit) begin
                $display("Timeout in case %s: no thread or frameDone for %0d cycles",
                         caseName, waitLimit);
                aborted = 1'b1;
            end
        end
        // Quiet after the frame end pulse
        if (done) begin
            repeat (8) begin
                @(negedge clk);
                if (frameDone || |threadValid) begin
                    $display("Error at %0t ns: activity after frameDone", $time);
                    errCount++;
                end
            end
        end
        testCount++;
        if (errCount != errStart || aborted) begin
            testFails++;
        end
        $display("Test %s: %0d threads, %0d errors", caseName, n, errCount - errStart);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        string line;
        string caseName;
        int    fd;
        int    rc;
        int    mode;
        int    cases;
        fixedT vals [0:19];
        cases = 0;
        resetn <= 1'b0;
        arm    <= 1'b0;
        start  <= 1'b0;
        camPos <= '0;
        camBlc <= '0;
        camRh  <= '0;
        camRv  <= '0;
        camCub <= '0;
        camCvb <= '0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        idleTest();
        fd = $fopen(casePath, "r");
        if (fd == 0) begin
            $display("Cannot open the case file %s", casePath);
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            rc = $sscanf(line,
                "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                caseName, mode, vals[0], vals[1], vals[2], vals[3], vals[4], vals[5],
                vals[6], vals[7], vals[8], vals[9], vals[10], vals[11], vals[12],
                vals[13], vals[14], vals[15], vals[16], vals[17], vals[18], vals[19]);
            if (rc != 22) begin
                $display("Malformed line in the case file: %s", line);
                errCount++;
                continue;
            end
            // New camera while the generator is idle
            @(posedge clk);
            bpMode <= mode;
            camPos <= {vals[0], vals[1], vals[2]};
            camBlc <= {vals[3], vals[4], vals[5]};
            camRh  <= {vals[6], vals[7], vals[8]};
            camRv  <= {vals[9], vals[10], vals[11]};
            camCub <= vals[12];
            camCvb <= vals[13];
            runFrame(caseName, {vals[14], vals[15], vals[16]}, {vals[17], vals[18], vals[19]});
            cases++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (cases == 0) begin
            $display("No test case was read from %s", casePath);
            errCount++;
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, testFails, errCount);
        if (errCount == 0 && testFails == 0 && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verif/rayGenCases.txt */
# name mode pos(x y z) blc(x y z) rh(x y z) rv(x y z) cub cvb dir00(x y z) dirLast(x y z)
# Raw Q16.16 words in hex; mode 0 no back-pressure, 1 stall on core 0, 2 random
# Eye at the origin, unit axes, plane one unit ahead
plain  0 0 0 0 0 0 10000 10000 0 0 0 10000 0 2000 4000 0 c000 10000 e000 0 10000
# Eye offset so that some components go negative
offset 1 10000 20000 30000 8000 8000 40000 20000 0 0 0 18000 0 4000 8000 ffff8000 c000 10000 30000 fffe8000 10000
# Tilted axes and an inexact vertical step
random 2 0 0 0 0 0 20000 30000 10000 0 0 20000 8000 6000 5555 0 1fffe 27fff 7e000 2a000 20000
# Repeat of the first camera under random stalls
again  2 0 0 0 0 0 10000 10000 0 0 0 10000 0 2000 4000 0 c000 10000 e000 0 10000

/* sources.f */
hdl/rayGenPkg.sv
hdl/scanIf.sv
hdl/pixelScanner.sv
hdl/threadGenFsm.sv
hdl/rayDirUnit.sv
hdl/threadDispatch.sv
hdl/rayGenTop.sv
verif/rayGenTb.sv

/* Makefile */
VERILATOR = verilator
TOP       = rayGenTb
FILELIST  = sources.f
OBJDIR    = obj_dir
SIMFLAGS  = --binary --timing -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing -Wall
PASSTEXT  = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
